//--- list.f
hw/id_pkg.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/operand_resolve.sv
hw/id_stage.sv
dv/id_stage_tb.sv

//--- dv/id_stage_tb.sv
`timescale 1ns/1ns
`default_nettype none

module id_stage_tb;

	localparam int WAIT_LIMIT = 4;
	localparam id_pkg::reg_write_t NO_WRITE = '0;

	// branch kinds of the reference model
	localparam int K_NONE = 0;
	localparam int K_ABS  = 1;
	localparam int K_REG  = 2;
	localparam int K_EQ   = 3;
	localparam int K_NE   = 4;
	localparam int K_LEZ  = 5;
	localparam int K_GTZ  = 6;

	localparam logic [5:0] R_FUNCTS [10] = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24,
		6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
	localparam logic [5:0] I_OPS [8] = '{6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f};
	localparam logic [5:0] SHIFT_FUNCTS [6] = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07};

	logic               clk;
	logic               reset_i;
	logic [31:0]        pc_i;
	logic [31:0]        inst_i;
	logic               is_in_delayslot_i;
	id_pkg::reg_write_t ex_fwd_i;
	id_pkg::reg_write_t mem_fwd_i;
	id_pkg::reg_write_t wb_i;
	id_pkg::ex_req_t    ex_o;
	id_pkg::branch_t    branch_o;

	logic [31:0]        shadow [32];
	id_pkg::ex_req_t    exp_ex;
	id_pkg::branch_t    exp_br;
	logic               pending;
	logic               hold_reset;
	int                 seed;
	int                 errors;
	int                 errors_at_start;
	int                 tests_passed;
	int                 tests_failed;

	id_stage dut (
		.clk               (clk),
		.reset_i           (reset_i),
		.pc_i              (pc_i),
		.inst_i            (inst_i),
		.is_in_delayslot_i (is_in_delayslot_i),
		.ex_fwd_i          (ex_fwd_i),
		.mem_fwd_i         (mem_fwd_i),
		.wb_i              (wb_i),
		.ex_o              (ex_o),
		.branch_o          (branch_o)
	);

	always #50 clk = ~clk;

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	function automatic id_pkg::alu_op_e funct_aluop(input logic [5:0] fn);
		case (fn)
			6'h00, 6'h04: return id_pkg::ALU_SLL;
			6'h02, 6'h06: return id_pkg::ALU_SRL;
			6'h03, 6'h07: return id_pkg::ALU_SRA;
			6'h08: return id_pkg::ALU_JR;
			6'h09: return id_pkg::ALU_JALR;
			6'h20: return id_pkg::ALU_ADD;
			6'h21: return id_pkg::ALU_ADDU;
			6'h22: return id_pkg::ALU_SUB;
			6'h23: return id_pkg::ALU_SUBU;
			6'h24: return id_pkg::ALU_AND;
			6'h25: return id_pkg::ALU_OR;
			6'h26: return id_pkg::ALU_XOR;
			6'h27: return id_pkg::ALU_NOR;
			6'h2a: return id_pkg::ALU_SLT;
			6'h2b: return id_pkg::ALU_SLTU;
			default: return id_pkg::ALU_NOP;
		endcase
	endfunction

	// LUI and the set-less-than immediates reuse the R-type ops
	function automatic id_pkg::alu_op_e opcode_aluop(input logic [5:0] op);
		case (op)
			6'h02: return id_pkg::ALU_J;
			6'h03: return id_pkg::ALU_JAL;
			6'h04: return id_pkg::ALU_BEQ;
			6'h05: return id_pkg::ALU_BNE;
			6'h06: return id_pkg::ALU_BLEZ;
			6'h07: return id_pkg::ALU_BGTZ;
			6'h08: return id_pkg::ALU_ADDI;
			6'h09: return id_pkg::ALU_ADDIU;
			6'h0a: return id_pkg::ALU_SLT;
			6'h0b: return id_pkg::ALU_SLTU;
			6'h0c: return id_pkg::ALU_AND;
			6'h0d, 6'h0f: return id_pkg::ALU_OR;
			6'h0e: return id_pkg::ALU_XOR;
			default: return id_pkg::ALU_NOP;
		endcase
	endfunction

	// EX result first, then MEM, then the stored word
	function automatic logic [31:0] newest_value(
		input logic [4:0]         addr,
		input logic [31:0]        stored,
		input id_pkg::reg_write_t exf,
		input id_pkg::reg_write_t memf
	);
		if (exf.wreg && (exf.wd == addr))
			return exf.wdata;
		if (memf.wreg && (memf.wd == addr))
			return memf.wdata;
		return stored;
	endfunction

	function automatic void predict(
		input logic [31:0]        inst,
		input logic [31:0]        pc,
		input logic [31:0]        regs [32],
		input id_pkg::reg_write_t exf,
		input id_pkg::reg_write_t memf,
		input logic               ds,
		output id_pkg::ex_req_t   ex,
		output id_pkg::branch_t   br
	);
		logic [5:0]  op;
		logic [5:0]  fn;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [4:0]  sa;
		logic [31:0] simm;
		logic [31:0] imm;
		logic [31:0] pc4;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] tgt;
		logic        use_rs;
		logic        use_rt;
		logic        link;
		logic        taken;
		logic        ok;
		int          kind;

		op     = inst[31:26];
		rs     = inst[25:21];
		rt     = inst[20:16];
		rd     = inst[15:11];
		sa     = inst[10:6];
		fn     = inst[5:0];
		simm   = {{16{inst[15]}}, inst[15:0]};
		pc4    = pc + 32'd4;
		ex     = '0;
		br     = '0;
		imm    = '0;
		tgt    = '0;
		use_rs = 1'b0;
		use_rt = 1'b0;
		link   = 1'b0;
		taken  = 1'b0;
		ok     = 1'b1;
		kind   = K_NONE;
		ex.aluop = (op == 6'h00) ? funct_aluop(fn) : opcode_aluop(op);
		case (op)
			6'h00: begin
				ex.wd   = rd;
				ex.wreg = 1'b1;
				use_rs  = 1'b1;
				use_rt  = 1'b1;
				ok      = (sa == 5'd0);
				case (fn)
					// shift amount comes from the instruction and the rs field is zero
					6'h00, 6'h02, 6'h03: begin
						ex.alusel = id_pkg::SEL_SHIFT;
						use_rs    = 1'b0;
						imm       = {27'b0, sa};
						ok        = (rs == 5'd0);
					end
					6'h04, 6'h06, 6'h07: ex.alusel = id_pkg::SEL_SHIFT;
					6'h24, 6'h25, 6'h26, 6'h27: ex.alusel = id_pkg::SEL_LOGIC;
					6'h20, 6'h21, 6'h22, 6'h23, 6'h2a, 6'h2b: ex.alusel = id_pkg::SEL_ARITH;
					6'h08, 6'h09: begin
						ex.alusel = id_pkg::SEL_JUMP_BRANCH;
						use_rt    = 1'b0;
						link      = (fn == 6'h09);
						ex.wreg   = link;
						ex.wd     = link ? rd : 5'd0;
						kind      = K_REG;
					end
					default: ok = 1'b0;
				endcase
			end
			6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
				ex.alusel = id_pkg::SEL_LOGIC;
				use_rs    = 1'b1;
				ex.wd     = rt;
				ex.wreg   = 1'b1;
				imm       = (op == 6'h0f) ? {inst[15:0], 16'h0} : {16'h0, inst[15:0]};
			end
			6'h08, 6'h09, 6'h0a, 6'h0b: begin
				ex.alusel = id_pkg::SEL_ARITH;
				use_rs    = 1'b1;
				ex.wd     = rt;
				ex.wreg   = 1'b1;
				imm       = simm;
			end
			6'h02, 6'h03: begin
				ex.alusel = id_pkg::SEL_JUMP_BRANCH;
				link      = (op == 6'h03);
				ex.wreg   = link;
				ex.wd     = link ? 5'd31 : 5'd0;
				kind      = K_ABS;
			end
			6'h04, 6'h05, 6'h06, 6'h07: begin
				ex.alusel = id_pkg::SEL_JUMP_BRANCH;
				use_rs    = 1'b1;
				use_rt    = (op == 6'h04) || (op == 6'h05);
				kind      = (op == 6'h04) ? K_EQ : (op == 6'h05) ? K_NE :
					(op == 6'h06) ? K_LEZ : K_GTZ;
			end
			default: ok = 1'b0;
		endcase
		// anything unknown is a NOP record
		if (!ok) begin
			ex     = '0;
			imm    = '0;
			use_rs = 1'b0;
			use_rt = 1'b0;
			link   = 1'b0;
			kind   = K_NONE;
		end
		a = use_rs ? newest_value(rs, regs[rs], exf, memf) : imm;
		b = use_rt ? newest_value(rt, regs[rt], exf, memf) : imm;
		ex.reg1         = a;
		ex.reg2         = b;
		ex.link_addr    = link ? (pc + 32'd8) : 32'd0;
		ex.in_delayslot = ds;
		case (kind)
			K_ABS: begin
				taken = 1'b1;
				tgt   = {pc4[31:28], inst[25:0], 2'b00};
			end
			K_REG: begin
				taken = 1'b1;
				tgt   = a;
			end
			K_EQ:  taken = (a == b);
			K_NE:  taken = (a != b);
			K_LEZ: taken = ($signed(a) <= 0);
			K_GTZ: taken = ($signed(a) > 0);
			default: ;
		endcase
		if (taken && (kind >= K_EQ))
			tgt = pc4 + {simm[29:0], 2'b00};
		br.flag              = taken;
		br.target            = tgt;
		br.next_in_delayslot = taken;
	endfunction

	////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////

	function automatic logic [31:0] encode_r(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] sa, input logic [5:0] fn);
		return {6'h00, rs, rt, rd, sa, fn};
	endfunction

	function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm16);
		return {op, rs, rt, imm16};
	endfunction

	function automatic id_pkg::reg_write_t reg_write(input logic wreg, input logic [4:0] wd,
		input logic [31:0] wdata);
		return {wreg, wd, wdata};
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
		errors++;
	endtask

	// one instruction per cycle, then wait until the compare process has run
	task automatic drive_inst(
		input logic [31:0]        inst,
		input logic [31:0]        pc,
		input id_pkg::reg_write_t exf,
		input id_pkg::reg_write_t memf,
		input id_pkg::reg_write_t wb,
		input logic               ds
	);
		int guard;

		@(posedge clk);
		#5;
		reset_i           = hold_reset;
		inst_i            = inst;
		pc_i              = pc;
		ex_fwd_i          = exf;
		mem_fwd_i         = memf;
		wb_i              = wb;
		is_in_delayslot_i = ds;
		// writeback shows up in the same cycle through write-through
		if (!hold_reset && wb.wreg && (wb.wd != 5'd0))
			shadow[wb.wd] = wb.wdata;
		if (hold_reset) begin
			exp_ex = '0;
			exp_br = '0;
		end else begin
			predict(inst, pc, shadow, exf, memf, ds, exp_ex, exp_br);
		end
		pending = 1'b1;
		guard   = 0;
		while (pending && (guard < WAIT_LIMIT)) begin
			@(negedge clk);
			guard++;
		end
		if (pending) begin
			$display("timeout: outputs were not compared within %0d cycles at %0t",
				WAIT_LIMIT, $time);
			errors++;
			pending = 1'b0;
		end
	endtask

	task automatic finish_test(input string name);
		if (errors == errors_at_start) begin
			$display("test %s: ok", name);
			tests_passed++;
		end else begin
			$display("test %s: %0d errors", name, errors - errors_at_start);
			tests_failed++;
		end
		errors_at_start = errors;
	endtask

	////////////////////////////////////////
	// compare process
	////////////////////////////////////////

	always begin
		@(posedge clk);
		#45;
		if (pending) begin
			if (ex_o.aluop !== exp_ex.aluop)
				report_mismatch("ex_o.aluop", 32'(exp_ex.aluop), 32'(ex_o.aluop));
			if (ex_o.alusel !== exp_ex.alusel)
				report_mismatch("ex_o.alusel", 32'(exp_ex.alusel), 32'(ex_o.alusel));
			if (ex_o.reg1 !== exp_ex.reg1)
				report_mismatch("ex_o.reg1", exp_ex.reg1, ex_o.reg1);
			if (ex_o.reg2 !== exp_ex.reg2)
				report_mismatch("ex_o.reg2", exp_ex.reg2, ex_o.reg2);
			if (ex_o.wd !== exp_ex.wd)
				report_mismatch("ex_o.wd", 32'(exp_ex.wd), 32'(ex_o.wd));
			if (ex_o.wreg !== exp_ex.wreg)
				report_mismatch("ex_o.wreg", 32'(exp_ex.wreg), 32'(ex_o.wreg));
			if (ex_o.link_addr !== exp_ex.link_addr)
				report_mismatch("ex_o.link_addr", exp_ex.link_addr, ex_o.link_addr);
			if (ex_o.in_delayslot !== exp_ex.in_delayslot)
				report_mismatch("ex_o.in_delayslot", 32'(exp_ex.in_delayslot),
					32'(ex_o.in_delayslot));
			if (branch_o.flag !== exp_br.flag)
				report_mismatch("branch_o.flag", 32'(exp_br.flag), 32'(branch_o.flag));
			if (branch_o.target !== exp_br.target)
				report_mismatch("branch_o.target", exp_br.target, branch_o.target);
			if (branch_o.next_in_delayslot !== exp_br.next_in_delayslot)
				report_mismatch("branch_o.next_in_delayslot", 32'(exp_br.next_in_delayslot),
					32'(branch_o.next_in_delayslot));
			pending = 1'b0;
		end
	end

	////////////////////////////////////////
	// tests
	////////////////////////////////////////

	task automatic reset_and_clear();
		hold_reset = 1'b1;
		// random writes during reset must not stick
		for (int i = 0; i < 16; i++)
			drive_inst($random(seed), $random(seed), NO_WRITE, NO_WRITE,
				reg_write(1'b1, 5'(i + 1), $random(seed)), 1'b1);
		hold_reset = 1'b0;
		for (int i = 0; i < 32; i++)
			drive_inst(encode_r(5'(i), 5'(i), 5'd1, 5'd0, 6'h25), 32'h100, NO_WRITE,
				NO_WRITE, NO_WRITE, 1'b0);
	endtask

	task automatic alu_instructions();
		logic [31:0] r;
		logic [31:0] inst;
		int          idx;

		// fill r1..r31 and read each value back through write-through
		for (int i = 1; i < 32; i++)
			drive_inst(encode_r(5'(i), 5'd0, 5'd2, 5'd0, 6'h25), 32'h200, NO_WRITE, NO_WRITE,
				reg_write(1'b1, 5'(i), $random(seed)), 1'b0);
		for (int i = 0; i < 200; i++) begin
			r = $random(seed);
			if (r[0]) begin
				idx  = r[19:16] % 10;
				inst = encode_r(r[5:1], r[10:6], r[15:11], 5'd0, R_FUNCTS[idx]);
			end else begin
				idx  = r[18:16] % 8;
				inst = encode_i(I_OPS[idx], r[5:1], r[10:6], r[31:20] ^ r[15:0]);
			end
			drive_inst(inst, {r[31:2], 2'b00}, NO_WRITE, NO_WRITE, NO_WRITE, r[22]);
		end
	endtask

	task automatic shift_instructions();
		logic [31:0] r;
		logic [31:0] inst;
		int          idx;

		for (int i = 0; i < 120; i++) begin
			r   = $random(seed);
			idx = r[19:16] % 6;
			if (idx < 3)
				inst = encode_r(5'd0, r[5:1], r[10:6], r[15:11], SHIFT_FUNCTS[idx]);
			else
				inst = encode_r(r[24:20], r[5:1], r[10:6], 5'd0, SHIFT_FUNCTS[idx]);
			drive_inst(inst, 32'h400, NO_WRITE, NO_WRITE, NO_WRITE, r[25]);
		end
	endtask

	task automatic forwarding_paths();
		logic [31:0] r;
		logic [31:0] inst;

		// EX over MEM, MEM over register file, then no match
		drive_inst(encode_r(5'd3, 5'd4, 5'd2, 5'd0, 6'h25), 32'h500,
			reg_write(1'b1, 5'd3, $random(seed)), reg_write(1'b1, 5'd3, $random(seed)),
			NO_WRITE, 1'b0);
		drive_inst(encode_r(5'd3, 5'd4, 5'd2, 5'd0, 6'h25), 32'h504,
			reg_write(1'b1, 5'd4, $random(seed)), reg_write(1'b1, 5'd3, $random(seed)),
			NO_WRITE, 1'b0);
		drive_inst(encode_r(5'd3, 5'd4, 5'd2, 5'd0, 6'h25), 32'h508,
			reg_write(1'b0, 5'd3, $random(seed)), reg_write(1'b1, 5'd9, $random(seed)),
			NO_WRITE, 1'b0);
		drive_inst(encode_r(5'd3, 5'd3, 5'd2, 5'd0, 6'h21), 32'h50c, NO_WRITE, NO_WRITE,
			reg_write(1'b1, 5'd3, $random(seed)), 1'b0);
		// r0 stays zero unless a forward names it
		drive_inst(encode_r(5'd0, 5'd0, 5'd2, 5'd0, 6'h25), 32'h510, NO_WRITE, NO_WRITE,
			reg_write(1'b1, 5'd0, $random(seed)), 1'b0);
		drive_inst(encode_r(5'd0, 5'd0, 5'd2, 5'd0, 6'h25), 32'h514,
			reg_write(1'b1, 5'd0, $random(seed)), NO_WRITE, NO_WRITE, 1'b0);
		drive_inst(encode_r(5'd0, 5'd5, 5'd2, 5'd0, 6'h25), 32'h518, NO_WRITE,
			reg_write(1'b1, 5'd0, $random(seed)), NO_WRITE, 1'b0);
		for (int i = 0; i < 150; i++) begin
			r = $random(seed);
			if (r[6])
				inst = encode_r({2'b00, r[2:0]}, {2'b00, r[5:3]}, 5'd1, 5'd0, 6'h21);
			else
				inst = encode_i(6'h09, {2'b00, r[2:0]}, 5'd1, r[31:16]);
			drive_inst(inst, 32'h600,
				reg_write(r[7], {2'b00, r[10:8]}, $random(seed)),
				reg_write(r[11], {2'b00, r[14:12]}, $random(seed)),
				reg_write(r[15], {2'b00, r[18:16]}, $random(seed)), r[19]);
		end
	endtask

	task automatic jumps_and_branches();
		logic [31:0] r;
		logic [31:0] pc;
		logic [31:0] inst;
		logic [4:0]  rs;
		logic [4:0]  rt;

		for (int i = 0; i < 240; i++) begin
			pc = $random(seed);
			pc = {pc[31:2], 2'b00};
			r  = $random(seed);
			rs = {2'b00, r[2:0]};
			// equal sources make BEQ taken and BNE not taken
			rt = r[3] ? rs : {2'b00, r[6:4]};
			case (r[9:7])
				3'd0: inst = {6'h02, r[31:6]};
				3'd1: inst = {6'h03, r[31:6]};
				3'd2: inst = encode_r(rs, 5'd0, 5'd0, 5'd0, 6'h08);
				3'd3: inst = encode_r(rs, 5'd0, r[16:12], 5'd0, 6'h09);
				3'd4: inst = encode_i(6'h04, rs, rt, r[31:16]);
				3'd5: inst = encode_i(6'h05, rs, rt, r[31:16]);
				3'd6: inst = encode_i(6'h06, rs, 5'd0, r[31:16]);
				default: inst = encode_i(6'h07, rs, 5'd0, r[31:16]);
			endcase
			drive_inst(inst, pc, reg_write(r[10], rs, $random(seed)), NO_WRITE, NO_WRITE,
				r[11]);
		end
	endtask

	task automatic unknown_encodings();
		logic [31:0] r;
		logic [31:0] inst;

		for (int i = 0; i < 60; i++) begin
			r = $random(seed);
			// opcodes from 0x10 up and SPECIAL functions 0x10 to 0x1f are not decoded
			if (r[30])
				inst = {r[31:26] | 6'h10, r[25:0]};
			else
				inst = {6'h00, r[25:6], 2'b01, r[3:0]};
			drive_inst(inst, 32'h800, reg_write(1'b1, r[25:21], $random(seed)),
				reg_write(1'b1, r[20:16], $random(seed)), NO_WRITE, r[4]);
		end
	endtask

	initial begin
		clk               = 1'b0;
		reset_i           = 1'b1;
		pc_i              = '0;
		inst_i            = '0;
		is_in_delayslot_i = 1'b0;
		ex_fwd_i          = '0;
		mem_fwd_i         = '0;
		wb_i              = '0;
		exp_ex            = '0;
		exp_br            = '0;
		pending           = 1'b0;
		hold_reset        = 1'b1;
		seed              = 36;
		errors            = 0;
		errors_at_start   = 0;
		tests_passed      = 0;
		tests_failed      = 0;
		for (int i = 0; i < 32; i++)
			shadow[i] = '0;

		reset_and_clear();
		finish_test("reset");
		alu_instructions();
		finish_test("logic and arithmetic");
		shift_instructions();
		finish_test("shifts");
		forwarding_paths();
		finish_test("forwarding");
		jumps_and_branches();
		finish_test("jumps and branches");
		unknown_encodings();
		finish_test("unknown encodings");

		$display("tests passed %0d, failed %0d", tests_passed, tests_failed);
		if ((errors == 0) && (tests_failed == 0)) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/id_stage.sv
`timescale 1ns/1ns
`default_nettype none

module id_stage (
	input  wire logic                      clk,
	input  wire logic                      reset_i,
	input  wire logic [id_pkg::DATA_W-1:0] pc_i,
	input  wire logic [id_pkg::DATA_W-1:0] inst_i,
	input  wire logic                      is_in_delayslot_i,
	input  wire id_pkg::reg_write_t        ex_fwd_i,
	input  wire id_pkg::reg_write_t        mem_fwd_i,
	input  wire id_pkg::reg_write_t        wb_i,
	output id_pkg::ex_req_t                ex_o,
	output id_pkg::branch_t                branch_o
);

	id_pkg::decode_t           dec;
	logic [id_pkg::DATA_W-1:0] rdata1;
	logic [id_pkg::DATA_W-1:0] rdata2;

	////////////////////////////////////////
	// decode, register read, resolve
	////////////////////////////////////////

	instr_decoder u_dec (
		.reset_i (reset_i),
		.inst_i  (inst_i),
		.dec_o   (dec)
	);

	// writeback is the only write port
	reg_file u_rf (
		.clk      (clk),
		.reset_i  (reset_i),
		.we_i     (wb_i),
		.raddr1_i (dec.reg1_addr),
		.raddr2_i (dec.reg2_addr),
		.re1_i    (dec.reg1_read),
		.re2_i    (dec.reg2_read),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2)
	);

	operand_resolve u_res (
		.reset_i           (reset_i),
		.dec_i             (dec),
		.rdata1_i          (rdata1),
		.rdata2_i          (rdata2),
		.ex_fwd_i          (ex_fwd_i),
		.mem_fwd_i         (mem_fwd_i),
		.pc_i              (pc_i),
		.is_in_delayslot_i (is_in_delayslot_i),
		.ex_o              (ex_o),
		.branch_o          (branch_o)
	);

endmodule

`default_nettype wire

//--- hw/operand_resolve.sv
`timescale 1ns/1ns
`default_nettype none

module operand_resolve (
	input  wire logic                      reset_i,
	input  wire id_pkg::decode_t           dec_i,
	input  wire logic [id_pkg::DATA_W-1:0] rdata1_i,
	input  wire logic [id_pkg::DATA_W-1:0] rdata2_i,
	input  wire id_pkg::reg_write_t        ex_fwd_i,
	input  wire id_pkg::reg_write_t        mem_fwd_i,
	input  wire logic [id_pkg::DATA_W-1:0] pc_i,
	input  wire logic                      is_in_delayslot_i,
	output id_pkg::ex_req_t                ex_o,
	output id_pkg::branch_t                branch_o
);

	logic [id_pkg::DATA_W-1:0] op1;
	logic [id_pkg::DATA_W-1:0] op2;
	logic [id_pkg::DATA_W-1:0] pc_plus_4;
	logic [id_pkg::DATA_W-1:0] pc_plus_8;
	logic [id_pkg::DATA_W-1:0] br_offset;
	logic [id_pkg::DATA_W-1:0] jump_target;
	logic                      taken;
	logic [id_pkg::DATA_W-1:0] target;

	// newest value wins: EX, then MEM, then register file, else immediate
	function automatic logic [id_pkg::DATA_W-1:0] pick_operand(
		input logic                          rd_en,
		input logic [id_pkg::REG_ADDR_W-1:0] addr,
		input logic [id_pkg::DATA_W-1:0]     rf_word,
		input logic [id_pkg::DATA_W-1:0]     imm,
		input id_pkg::reg_write_t            ex_fwd,
		input id_pkg::reg_write_t            mem_fwd
	);
		if (rd_en && ex_fwd.wreg && (ex_fwd.wd == addr))
			return ex_fwd.wdata;
		if (rd_en && mem_fwd.wreg && (mem_fwd.wd == addr))
			return mem_fwd.wdata;
		if (rd_en)
			return rf_word;
		return imm;
	endfunction

	assign op1 = pick_operand(dec_i.reg1_read, dec_i.reg1_addr, rdata1_i, dec_i.imm,
		ex_fwd_i, mem_fwd_i);
	assign op2 = pick_operand(dec_i.reg2_read, dec_i.reg2_addr, rdata2_i, dec_i.imm,
		ex_fwd_i, mem_fwd_i);

	////////////////////////////////////////
	// control flow
	////////////////////////////////////////

	assign pc_plus_4   = pc_i + 32'd4;
	assign pc_plus_8   = pc_i + 32'd8;
	assign br_offset   = {{14{dec_i.instr_index[15]}}, dec_i.instr_index[15:0], 2'b00};
	assign jump_target = {pc_plus_4[31:28], dec_i.instr_index, 2'b00};

	always_comb begin
		taken  = 1'b0;
		target = '0;
		case (dec_i.branch_kind)
			id_pkg::BK_JUMP_ABS: begin
				taken  = 1'b1;
				target = jump_target;
			end
			id_pkg::BK_JUMP_REG: begin
				taken  = 1'b1;
				target = op1;
			end
			id_pkg::BK_BR_EQ:  taken = (op1 == op2);
			id_pkg::BK_BR_NE:  taken = (op1 != op2);
			id_pkg::BK_BR_GTZ: taken = !op1[31] && (op1 != '0);
			id_pkg::BK_BR_LEZ: taken = op1[31] || (op1 == '0);
			default: ;
		endcase
		// conditional branches are pc-relative
		if (taken && (dec_i.branch_kind inside {id_pkg::BK_BR_EQ, id_pkg::BK_BR_NE,
				id_pkg::BK_BR_GTZ, id_pkg::BK_BR_LEZ})) begin
			target = pc_plus_4 + br_offset;
		end
	end

	////////////////////////////////////////
	// outputs
	////////////////////////////////////////

	always_comb begin
		ex_o     = '0;
		branch_o = '0;
		if (!reset_i) begin
			ex_o.aluop        = dec_i.aluop;
			ex_o.alusel       = dec_i.alusel;
			ex_o.reg1         = op1;
			ex_o.reg2         = op2;
			ex_o.wd           = dec_i.wd;
			ex_o.wreg         = dec_i.wreg;
			ex_o.link_addr    = dec_i.link ? pc_plus_8 : '0;
			ex_o.in_delayslot = is_in_delayslot_i;

			branch_o.flag              = taken;
			branch_o.target            = target;
			branch_o.next_in_delayslot = taken;
		end
	end

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
	input  wire logic                          clk,
	input  wire logic                          reset_i,
	input  wire id_pkg::reg_write_t            we_i,
	input  wire logic [id_pkg::REG_ADDR_W-1:0] raddr1_i,
	input  wire logic [id_pkg::REG_ADDR_W-1:0] raddr2_i,
	input  wire logic                          re1_i,
	input  wire logic                          re2_i,
	output logic [id_pkg::DATA_W-1:0]          rdata1_o,
	output logic [id_pkg::DATA_W-1:0]          rdata2_o
);

	logic [id_pkg::DATA_W-1:0] regs [id_pkg::NUM_REGS];

	// r0 is never written, so it stays at its reset value of zero
	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < id_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i.wreg && (we_i.wd != '0)) begin
			regs[we_i.wd] <= we_i.wdata;
		end
	end

	////////////////////////////////////////
	// read ports
	////////////////////////////////////////

	// disabled port or r0 gives zero, a same-cycle write is passed through
	function automatic logic [id_pkg::DATA_W-1:0] read_port(
		input logic                          re,
		input logic [id_pkg::REG_ADDR_W-1:0] addr,
		input logic [id_pkg::DATA_W-1:0]     stored,
		input id_pkg::reg_write_t            wr
	);
		if (!re || (addr == '0))
			return '0;
		if (wr.wreg && (wr.wd == addr))
			return wr.wdata;
		return stored;
	endfunction

	assign rdata1_o = read_port(re1_i, raddr1_i, regs[raddr1_i], we_i);
	assign rdata2_o = read_port(re2_i, raddr2_i, regs[raddr2_i], we_i);

endmodule

`default_nettype wire

//--- hw/instr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
	input  wire logic                      reset_i,
	input  wire logic [id_pkg::DATA_W-1:0] inst_i,
	output id_pkg::decode_t                dec_o
);

	id_pkg::opcode_e                 op;
	id_pkg::funct_e                  funct;
	logic [id_pkg::REG_ADDR_W-1:0]   rs;
	logic [id_pkg::REG_ADDR_W-1:0]   rt;
	logic [id_pkg::REG_ADDR_W-1:0]   rd;
	logic [4:0]                      shamt;
	logic [15:0]                     imm16;
	id_pkg::alu_op_e                 fn_aluop;
	id_pkg::alu_op_e                 op_aluop;

	assign op    = id_pkg::opcode_e'(inst_i[31:26]);
	assign rs    = inst_i[25:21];
	assign rt    = inst_i[20:16];
	assign rd    = inst_i[15:11];
	assign shamt = inst_i[10:6];
	assign funct = id_pkg::funct_e'(inst_i[5:0]);
	assign imm16 = inst_i[15:0];

	// variable and immediate shifts share one ALU op
	function automatic id_pkg::alu_op_e funct_to_aluop(input id_pkg::funct_e f);
		case (f)
			id_pkg::FN_SLL, id_pkg::FN_SLLV: return id_pkg::ALU_SLL;
			id_pkg::FN_SRL, id_pkg::FN_SRLV: return id_pkg::ALU_SRL;
			id_pkg::FN_SRA, id_pkg::FN_SRAV: return id_pkg::ALU_SRA;
			id_pkg::FN_JR:   return id_pkg::ALU_JR;
			id_pkg::FN_JALR: return id_pkg::ALU_JALR;
			id_pkg::FN_ADD:  return id_pkg::ALU_ADD;
			id_pkg::FN_ADDU: return id_pkg::ALU_ADDU;
			id_pkg::FN_SUB:  return id_pkg::ALU_SUB;
			id_pkg::FN_SUBU: return id_pkg::ALU_SUBU;
			id_pkg::FN_AND:  return id_pkg::ALU_AND;
			id_pkg::FN_OR:   return id_pkg::ALU_OR;
			id_pkg::FN_XOR:  return id_pkg::ALU_XOR;
			id_pkg::FN_NOR:  return id_pkg::ALU_NOR;
			id_pkg::FN_SLT:  return id_pkg::ALU_SLT;
			id_pkg::FN_SLTU: return id_pkg::ALU_SLTU;
			default:         return id_pkg::ALU_NOP;
		endcase
	endfunction

	// LUI is an OR against r0 with the immediate in the upper half
	function automatic id_pkg::alu_op_e opcode_to_aluop(input id_pkg::opcode_e o);
		case (o)
			id_pkg::OP_ORI, id_pkg::OP_LUI: return id_pkg::ALU_OR;
			id_pkg::OP_ANDI:  return id_pkg::ALU_AND;
			id_pkg::OP_XORI:  return id_pkg::ALU_XOR;
			id_pkg::OP_ADDI:  return id_pkg::ALU_ADDI;
			id_pkg::OP_ADDIU: return id_pkg::ALU_ADDIU;
			id_pkg::OP_SLTI:  return id_pkg::ALU_SLT;
			id_pkg::OP_SLTIU: return id_pkg::ALU_SLTU;
			id_pkg::OP_J:     return id_pkg::ALU_J;
			id_pkg::OP_JAL:   return id_pkg::ALU_JAL;
			id_pkg::OP_BEQ:   return id_pkg::ALU_BEQ;
			id_pkg::OP_BNE:   return id_pkg::ALU_BNE;
			id_pkg::OP_BGTZ:  return id_pkg::ALU_BGTZ;
			id_pkg::OP_BLEZ:  return id_pkg::ALU_BLEZ;
			default:          return id_pkg::ALU_NOP;
		endcase
	endfunction

	assign fn_aluop = funct_to_aluop(funct);
	assign op_aluop = opcode_to_aluop(op);

	////////////////////////////////////////
	// decode
	////////////////////////////////////////

	always_comb begin
		// all-zero record is the NOP
		dec_o = '0;
		if (!reset_i) begin
			dec_o.reg1_addr   = rs;
			dec_o.reg2_addr   = rt;
			dec_o.instr_index = inst_i[25:0];
			case (op)
				id_pkg::OP_SPECIAL: begin
					case (funct)
						// shift by shamt, rs field must be zero
						id_pkg::FN_SLL, id_pkg::FN_SRL, id_pkg::FN_SRA: begin
							if (rs == '0) begin
								dec_o.aluop     = fn_aluop;
								dec_o.alusel    = id_pkg::SEL_SHIFT;
								dec_o.reg2_read = 1'b1;
								dec_o.imm       = {27'b0, shamt};
								dec_o.wd        = rd;
								dec_o.wreg      = 1'b1;
							end
						end
						id_pkg::FN_SLLV, id_pkg::FN_SRLV, id_pkg::FN_SRAV,
						id_pkg::FN_AND, id_pkg::FN_OR, id_pkg::FN_XOR, id_pkg::FN_NOR,
						id_pkg::FN_ADD, id_pkg::FN_ADDU, id_pkg::FN_SUB, id_pkg::FN_SUBU,
						id_pkg::FN_SLT, id_pkg::FN_SLTU: begin
							if (shamt == '0) begin
								dec_o.aluop     = fn_aluop;
								dec_o.reg1_read = 1'b1;
								dec_o.reg2_read = 1'b1;
								dec_o.wd        = rd;
								dec_o.wreg      = 1'b1;
								if (funct inside {id_pkg::FN_SLLV, id_pkg::FN_SRLV,
										id_pkg::FN_SRAV}) begin
									dec_o.alusel = id_pkg::SEL_SHIFT;
								end else if (funct inside {id_pkg::FN_AND, id_pkg::FN_OR,
										id_pkg::FN_XOR, id_pkg::FN_NOR}) begin
									dec_o.alusel = id_pkg::SEL_LOGIC;
								end else begin
									dec_o.alusel = id_pkg::SEL_ARITH;
								end
							end
						end
						// JALR links into rd, JR writes nothing
						id_pkg::FN_JR, id_pkg::FN_JALR: begin
							if (shamt == '0) begin
								dec_o.aluop       = fn_aluop;
								dec_o.alusel      = id_pkg::SEL_JUMP_BRANCH;
								dec_o.reg1_read   = 1'b1;
								dec_o.branch_kind = id_pkg::BK_JUMP_REG;
								if (funct == id_pkg::FN_JALR) begin
									dec_o.wd   = rd;
									dec_o.wreg = 1'b1;
									dec_o.link = 1'b1;
								end
							end
						end
						default: ;
					endcase
				end
				id_pkg::OP_ORI, id_pkg::OP_ANDI, id_pkg::OP_XORI, id_pkg::OP_LUI: begin
					dec_o.aluop     = op_aluop;
					dec_o.alusel    = id_pkg::SEL_LOGIC;
					dec_o.reg1_read = 1'b1;
					dec_o.wd        = rt;
					dec_o.wreg      = 1'b1;
					if (op == id_pkg::OP_LUI)
						dec_o.imm = {imm16, 16'h0};
					else
						dec_o.imm = {16'h0, imm16};
				end
				id_pkg::OP_ADDI, id_pkg::OP_ADDIU, id_pkg::OP_SLTI, id_pkg::OP_SLTIU: begin
					dec_o.aluop     = op_aluop;
					dec_o.alusel    = id_pkg::SEL_ARITH;
					dec_o.reg1_read = 1'b1;
					dec_o.imm       = {{16{imm16[15]}}, imm16};
					dec_o.wd        = rt;
					dec_o.wreg      = 1'b1;
				end
				id_pkg::OP_J, id_pkg::OP_JAL: begin
					dec_o.aluop       = op_aluop;
					dec_o.alusel      = id_pkg::SEL_JUMP_BRANCH;
					dec_o.branch_kind = id_pkg::BK_JUMP_ABS;
					if (op == id_pkg::OP_JAL) begin
						dec_o.wd   = id_pkg::REG_ADDR_W'(id_pkg::LINK_REG);
						dec_o.wreg = 1'b1;
						dec_o.link = 1'b1;
					end
				end
				id_pkg::OP_BEQ, id_pkg::OP_BNE, id_pkg::OP_BGTZ, id_pkg::OP_BLEZ: begin
					dec_o.aluop     = op_aluop;
					dec_o.alusel    = id_pkg::SEL_JUMP_BRANCH;
					dec_o.reg1_read = 1'b1;
					// BGTZ and BLEZ only compare rs against zero
					dec_o.reg2_read = (op == id_pkg::OP_BEQ) || (op == id_pkg::OP_BNE);
					case (op)
						id_pkg::OP_BEQ:  dec_o.branch_kind = id_pkg::BK_BR_EQ;
						id_pkg::OP_BNE:  dec_o.branch_kind = id_pkg::BK_BR_NE;
						id_pkg::OP_BGTZ: dec_o.branch_kind = id_pkg::BK_BR_GTZ;
						default:         dec_o.branch_kind = id_pkg::BK_BR_LEZ;
					endcase
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/id_pkg.sv
`default_nettype none

package id_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	localparam int DATA_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;
	localparam int LINK_REG   = 31;

	////////////////////////////////////////
	// instruction fields
	////////////////////////////////////////

	// primary opcode, inst[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_J       = 6'b000010,
		OP_JAL     = 6'b000011,
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_BLEZ    = 6'b000110,
		OP_BGTZ    = 6'b000111,
		OP_ADDI    = 6'b001000,
		OP_ADDIU   = 6'b001001,
		OP_SLTI    = 6'b001010,
		OP_SLTIU   = 6'b001011,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_XORI    = 6'b001110,
		OP_LUI     = 6'b001111
	} opcode_e;

	// function field of SPECIAL, inst[5:0]
	typedef enum logic [5:0] {
		FN_SLL  = 6'b000000,
		FN_SRL  = 6'b000010,
		FN_SRA  = 6'b000011,
		FN_SLLV = 6'b000100,
		FN_SRLV = 6'b000110,
		FN_SRAV = 6'b000111,
		FN_JR   = 6'b001000,
		FN_JALR = 6'b001001,
		FN_ADD  = 6'b100000,
		FN_ADDU = 6'b100001,
		FN_SUB  = 6'b100010,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110,
		FN_NOR  = 6'b100111,
		FN_SLT  = 6'b101010,
		FN_SLTU = 6'b101011
	} funct_e;

	////////////////////////////////////////
	// ALU control
	////////////////////////////////////////

	// same codes as the EX stage expects
	typedef enum logic [7:0] {
		ALU_NOP   = 8'b00000000,
		ALU_AND   = 8'b00100100,
		ALU_OR    = 8'b00100101,
		ALU_XOR   = 8'b00100110,
		ALU_NOR   = 8'b00100111,
		ALU_SLL   = 8'b01111100,
		ALU_SRL   = 8'b00000010,
		ALU_SRA   = 8'b00000011,
		ALU_SLT   = 8'b00101010,
		ALU_SLTU  = 8'b00101011,
		ALU_ADD   = 8'b00100000,
		ALU_ADDU  = 8'b00100001,
		ALU_SUB   = 8'b00100010,
		ALU_SUBU  = 8'b00100011,
		ALU_ADDI  = 8'b01010101,
		ALU_ADDIU = 8'b01010110,
		ALU_J     = 8'b01001111,
		ALU_JAL   = 8'b01010000,
		ALU_JALR  = 8'b00001001,
		ALU_JR    = 8'b00001000,
		ALU_BEQ   = 8'b01010001,
		ALU_BNE   = 8'b01010010,
		ALU_BLEZ  = 8'b01010011,
		ALU_BGTZ  = 8'b01010100
	} alu_op_e;

	typedef enum logic [2:0] {
		SEL_NOP         = 3'b000,
		SEL_LOGIC       = 3'b001,
		SEL_SHIFT       = 3'b010,
		SEL_ARITH       = 3'b100,
		SEL_JUMP_BRANCH = 3'b110
	} alu_sel_e;

	typedef enum logic [2:0] {
		BK_NONE,
		BK_JUMP_ABS,
		BK_JUMP_REG,
		BK_BR_EQ,
		BK_BR_NE,
		BK_BR_GTZ,
		BK_BR_LEZ
	} branch_kind_e;

	////////////////////////////////////////
	// records
	////////////////////////////////////////

	// a register write in flight (EX, MEM or writeback)
	typedef struct packed {
		logic                  wreg;
		logic [REG_ADDR_W-1:0] wd;
		logic [DATA_W-1:0]     wdata;
	} reg_write_t;

	typedef struct packed {
		alu_op_e               aluop;
		alu_sel_e              alusel;
		logic                  reg1_read;
		logic                  reg2_read;
		logic [REG_ADDR_W-1:0] reg1_addr;
		logic [REG_ADDR_W-1:0] reg2_addr;
		logic [DATA_W-1:0]     imm;
		logic [REG_ADDR_W-1:0] wd;
		logic                  wreg;
		branch_kind_e          branch_kind;
		logic                  link;
		// raw inst[25:0], jump index or branch offset
		logic [25:0]           instr_index;
	} decode_t;

	typedef struct packed {
		alu_op_e               aluop;
		alu_sel_e              alusel;
		logic [DATA_W-1:0]     reg1;
		logic [DATA_W-1:0]     reg2;
		logic [REG_ADDR_W-1:0] wd;
		logic                  wreg;
		logic [DATA_W-1:0]     link_addr;
		logic                  in_delayslot;
	} ex_req_t;

	typedef struct packed {
		logic              flag;
		logic [DATA_W-1:0] target;
		logic              next_in_delayslot;
	} branch_t;

endpackage

`default_nettype wire
